// File: design/dbg_pkg.sv
// Debug bridge shared definitions

package dbg_pkg;

	// data register and register bank word
	localparam int DBG_WORD_W = 32;

	// register index width, enough for 16 registers
	localparam int DBG_ADDR_W = 4;

	typedef logic [DBG_WORD_W-1:0] dbg_word_t; // captured word or register contents
	typedef logic [DBG_ADDR_W-1:0] dbg_addr_t; // register index

	// command word layout
	//
	//  31        17 16   15   9  8   7   4 3    0
	// +------------+-----+------+---+------+------+
	// |  reserved  | clr | rsvd |inc| rsvd | addr |
	// +------------+-----+------+---+------+------+
	//
	// addr is taken modulo the register count, inc sets auto-increment,
	// clr wipes the whole bank and overrides the other fields
	localparam int CMD_ADDR_LSB    = 0;
	localparam int CMD_ADDR_W      = DBG_ADDR_W;
	localparam int CMD_AUTOINC_BIT = 8;
	localparam int CMD_CLEAR_BIT   = 16;

	// register select as latched from the JTAG chain
	localparam logic SEL_CMD  = 1'b0; // ce1, command register
	localparam logic SEL_DATA = 1'b1; // ce2, data register

endpackage

// File: design/jtag_dr_capture.sv
// JTAG data register capture
`timescale 1ns/1ps

module jtag_dr_capture #(
	parameter int SYNC_STAGES = 4
) (
	input  logic              clk48m,
	input  logic              jrstn,
	input  logic              jtck,
	input  logic              jtdi,
	input  logic              jshift,
	input  logic              jupdate,
	input  logic              jce1,
	input  logic              jce2,
	output dbg_pkg::dbg_word_t dr_word,
	output logic              dr_sel,
	output logic              dr_strobe
);

	localparam int W = dbg_pkg::DBG_WORD_W;

	// tck is sampled in the clk48m domain; bit 0 is the newest sample
	logic [SYNC_STAGES-1:0] tck_sync;
	logic                   tck_rise;

	logic               shift_d;   // jshift as seen at the previous tck rise
	dbg_pkg::dbg_word_t shift_reg; // the data register itself
	logic               sel;       // which user register the chain points at

	// rise seen at the old end of the chain, a few cycles after the real edge
	assign tck_rise = !tck_sync[SYNC_STAGES-1] && tck_sync[SYNC_STAGES-2];

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_sync <= '0;
		end else begin
			tck_sync <= {tck_sync[SYNC_STAGES-2:0], jtck};
		end
	end

	// shift, select and update all act on the detected rise
	always_ff @(posedge clk48m) begin
		dr_strobe <= 1'b0;
		if (!jrstn) begin
			shift_d   <= 1'b0;
			shift_reg <= '0;
			sel       <= dbg_pkg::SEL_CMD;
		end else if (tck_rise) begin
			// tdi enters at the top, lsb ends up at bit 0 after 32 shifts
			if (shift_d) begin
				shift_reg <= {jtdi, shift_reg[W-1:1]};
			end
			if (jce1 || jce2) begin
				sel <= jce2;
			end
			if (jupdate) begin
				dr_strobe <= 1'b1;
			end
			shift_d <= jshift;
		end
	end

	// holding register for the finished word, valid with the strobe
	always_ff @(posedge clk48m) begin
		if (tck_rise && jupdate) begin
			dr_word <= shift_reg;
			dr_sel  <= sel;
		end
	end

endmodule

// File: design/dbg_cmd_decoder.sv
// Debug command decoder
`timescale 1ns/1ps

module dbg_cmd_decoder #(
	parameter int REG_COUNT = 16
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  dbg_pkg::dbg_word_t dr_word,
	input  logic               dr_sel,
	input  logic               dr_strobe,
	output logic               wr_en,
	output dbg_pkg::dbg_addr_t wr_addr,
	output dbg_pkg::dbg_word_t wr_data,
	output logic               clr_all,
	output dbg_pkg::dbg_addr_t rd_addr
);

	localparam dbg_pkg::dbg_addr_t LAST_ADDR = dbg_pkg::dbg_addr_t'(REG_COUNT - 1);

	dbg_pkg::dbg_addr_t cur_addr;  // address the next data word goes to
	logic               autoinc;   // step cur_addr after every data word

	logic               is_cmd;
	logic               is_data;
	logic               cmd_clear;
	logic               cmd_inc;
	dbg_pkg::dbg_addr_t cmd_field;
	dbg_pkg::dbg_addr_t cmd_addr;  // field folded into the bank
	dbg_pkg::dbg_addr_t next_addr;

	assign is_cmd  = dr_strobe && (dr_sel == dbg_pkg::SEL_CMD);
	assign is_data = dr_strobe && (dr_sel == dbg_pkg::SEL_DATA);

	// command word fields
	assign cmd_clear = dr_word[dbg_pkg::CMD_CLEAR_BIT];
	assign cmd_inc   = dr_word[dbg_pkg::CMD_AUTOINC_BIT];
	assign cmd_field = dr_word[dbg_pkg::CMD_ADDR_LSB +: dbg_pkg::CMD_ADDR_W];

	// the bank need not be a power of two, so fold the field properly
	assign cmd_addr = dbg_pkg::dbg_addr_t'(cmd_field % REG_COUNT);

	// wrap after the last register
	assign next_addr = (cur_addr == LAST_ADDR) ? '0 : cur_addr + 1'b1;

	// address and auto-increment state
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			cur_addr <= '0;
			autoinc  <= 1'b0;
		end else if (is_cmd) begin
			if (cmd_clear) begin
				cur_addr <= '0; // auto-increment keeps its setting
			end else begin
				cur_addr <= cmd_addr;
				autoinc  <= cmd_inc;
			end
		end else if (is_data && autoinc) begin
			cur_addr <= next_addr;
		end
	end

	// write and clear pulses toward the register bank
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			wr_en   <= 1'b0;
			clr_all <= 1'b0;
		end else begin
			wr_en   <= is_data;
			clr_all <= is_cmd && cmd_clear;
		end
	end

	// write payload, only looked at together with wr_en
	always_ff @(posedge clk48m) begin
		if (is_data) begin
			wr_addr <= cur_addr; // address before any increment
			wr_data <= dr_word;
		end
	end

	assign rd_addr = cur_addr;

endmodule

// File: design/dbg_regfile.sv
// Debug register bank
`timescale 1ns/1ps

module dbg_regfile #(
	parameter int REG_COUNT = 16
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  logic               wr_en,
	input  dbg_pkg::dbg_addr_t wr_addr,
	input  dbg_pkg::dbg_word_t wr_data,
	input  logic               clr_all,
	input  dbg_pkg::dbg_addr_t rd_addr,
	output dbg_pkg::dbg_word_t dbgreg_out,
	output dbg_pkg::dbg_word_t dbg_ctrl
);

	// small enough to live in flops, and it must clear in one cycle
	dbg_pkg::dbg_word_t regs [REG_COUNT];

	// write port, clear wins over a write
	always_ff @(posedge clk48m) begin
		if (!jrstn || clr_all) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// registered readback of the current address
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			dbgreg_out <= '0;
		end else begin
			dbgreg_out <= regs[rd_addr];
		end
	end

	// register 0 drives the control word
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			dbg_ctrl <= '0;
		end else begin
			dbg_ctrl <= regs[0]; // follows a write one cycle late
		end
	end

endmodule

// File: design/jtag_debug_bridge.sv
// JTAG debug bridge top
`timescale 1ns/1ps

module jtag_debug_bridge #(
	parameter int REG_COUNT   = 16, // 2 to 16
	parameter int SYNC_STAGES = 4   // 3 to 6
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  logic               jtck,
	input  logic               jtdi,
	input  logic               jshift,
	input  logic               jupdate,
	input  logic               jce1,
	input  logic               jce2,
	output dbg_pkg::dbg_word_t dbgreg_out,
	output dbg_pkg::dbg_word_t dbg_ctrl
);

	// capture to decoder
	dbg_pkg::dbg_word_t dr_word;
	logic               dr_sel;
	logic               dr_strobe;

	// decoder to register bank
	logic               wr_en;
	dbg_pkg::dbg_addr_t wr_addr;
	dbg_pkg::dbg_word_t wr_data;
	logic               clr_all;
	dbg_pkg::dbg_addr_t rd_addr;

	jtag_dr_capture #(
		.SYNC_STAGES(SYNC_STAGES)
	) i_capture (
		.clk48m   (clk48m),
		.jrstn    (jrstn),
		.jtck     (jtck),
		.jtdi     (jtdi),
		.jshift   (jshift),
		.jupdate  (jupdate),
		.jce1     (jce1),
		.jce2     (jce2),
		.dr_word  (dr_word),
		.dr_sel   (dr_sel),
		.dr_strobe(dr_strobe)
	);

	dbg_cmd_decoder #(
		.REG_COUNT(REG_COUNT)
	) i_decoder (
		.clk48m   (clk48m),
		.jrstn    (jrstn),
		.dr_word  (dr_word),
		.dr_sel   (dr_sel),
		.dr_strobe(dr_strobe),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.clr_all  (clr_all),
		.rd_addr  (rd_addr)
	);

	dbg_regfile #(
		.REG_COUNT(REG_COUNT)
	) i_regfile (
		.clk48m    (clk48m),
		.jrstn     (jrstn),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.clr_all   (clr_all),
		.rd_addr   (rd_addr),
		.dbgreg_out(dbgreg_out),
		.dbg_ctrl  (dbg_ctrl)
	);

endmodule

// File: bench/dbg_checker.sv
// Debug register model and checker
`timescale 1ns/1ps

module dbg_checker #(
	parameter int REG_COUNT = 16
) (
	input  logic               clk48m,
	input  logic               jrstn,
	input  logic               hand_valid, // scanned word to apply to the model
	input  logic               hand_check, // compare only, no new word
	input  dbg_pkg::dbg_word_t hand_word,
	input  logic               hand_sel,
	input  dbg_pkg::dbg_word_t dbgreg_out,
	input  dbg_pkg::dbg_word_t dbg_ctrl,
	output int                 err_count,
	output int                 check_count
);

	// outputs have settled well before this many cycles after an update
	localparam int CHECK_DELAY = 6;

	dbg_pkg::dbg_word_t model_regs [REG_COUNT];
	int                 model_addr;
	logic               model_inc;

	// clearing wipes the bank and the address, auto-increment stays
	function automatic void clear_model();
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		model_addr = 0;
	endfunction

	// reference behavior of one captured word
	function automatic void apply_word(input dbg_pkg::dbg_word_t w, input logic sel);
		int field;
		field = int'(w[dbg_pkg::CMD_ADDR_LSB +: dbg_pkg::CMD_ADDR_W]);
		if (sel == dbg_pkg::SEL_CMD) begin
			if (w[dbg_pkg::CMD_CLEAR_BIT]) begin
				clear_model();
			end else begin
				model_addr = field % REG_COUNT;
				model_inc  = w[dbg_pkg::CMD_AUTOINC_BIT];
			end
		end else begin
			model_regs[model_addr] = w;
			if (model_inc) begin
				model_addr = (model_addr + 1) % REG_COUNT; // wraps past the last register
			end
		end
	endfunction

	function automatic dbg_pkg::dbg_word_t expected_readback();
		return model_regs[model_addr];
	endfunction

	task automatic compare_value(input string name, input dbg_pkg::dbg_word_t got,
			input dbg_pkg::dbg_word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	initial begin
		err_count   = 0;
		check_count = 0;
		model_inc   = 1'b0;
		clear_model();
		forever begin
			@(posedge clk48m);
			if (!jrstn) begin
				clear_model();
				model_inc = 1'b0;
			end else if (hand_valid || hand_check) begin
				if (hand_valid) begin
					apply_word(hand_word, hand_sel);
				end
				repeat (CHECK_DELAY) @(posedge clk48m);
				@(negedge clk48m); // sample away from the active edge
				compare_value("dbgreg_out", dbgreg_out, expected_readback());
				compare_value("dbg_ctrl", dbg_ctrl, model_regs[0]);
			end
		end
	end

endmodule

// File: bench/tb_jtag_debug.sv
// JTAG debug bridge testbench
`timescale 1ns/1ps

module tb_jtag_debug;

	localparam int REG_COUNT   = 16;
	localparam int HALF_TCK    = 8;                         // clk48m cycles per tck half
	localparam int NUM_SCANS   = 23;
	localparam int SCAN_LEN    = 34 * 2 * HALF_TCK + 24;    // longest scan plus gaps
	localparam int CYCLE_LIMIT = NUM_SCANS * SCAN_LEN + 200;

	logic               clk48m;
	logic               jrstn;
	logic               jtck;
	logic               jtdi;
	logic               jshift;
	logic               jupdate;
	logic               jce1;
	logic               jce2;
	dbg_pkg::dbg_word_t dbgreg_out;
	dbg_pkg::dbg_word_t dbg_ctrl;

	// handoff toward the checker
	logic               hand_valid;
	logic               hand_check;
	dbg_pkg::dbg_word_t hand_word;
	logic               hand_sel;
	int                 err_count;
	int                 check_count;

	logic [31:0]        lfsr_state;
	dbg_pkg::dbg_word_t sr_model;  // expected data register contents
	logic               shd_model; // jshift at the previous rise
	dbg_pkg::dbg_word_t cap_word;  // word an update rise will present
	int                 scan_count;
	int                 cycles = 0;

	always #2 clk48m = ~clk48m;

	jtag_debug_bridge i_dut (
		.clk48m    (clk48m),
		.jrstn     (jrstn),
		.jtck      (jtck),
		.jtdi      (jtdi),
		.jshift    (jshift),
		.jupdate   (jupdate),
		.jce1      (jce1),
		.jce2      (jce2),
		.dbgreg_out(dbgreg_out),
		.dbg_ctrl  (dbg_ctrl)
	);

	dbg_checker #(
		.REG_COUNT(REG_COUNT)
	) i_checker (
		.clk48m     (clk48m),
		.jrstn      (jrstn),
		.hand_valid (hand_valid),
		.hand_check (hand_check),
		.hand_word  (hand_word),
		.hand_sel   (hand_sel),
		.dbgreg_out (dbgreg_out),
		.dbg_ctrl   (dbg_ctrl),
		.err_count  (err_count),
		.check_count(check_count)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic rand_word(output dbg_pkg::dbg_word_t w);
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w[i]       = lfsr_state[0];
		end
	endtask

	function automatic dbg_pkg::dbg_word_t make_cmd(input int addr, input logic inc,
			input logic clr);
		dbg_pkg::dbg_word_t w;
		w = '0;
		w[dbg_pkg::CMD_ADDR_LSB +: dbg_pkg::CMD_ADDR_W] = dbg_pkg::dbg_addr_t'(addr);
		w[dbg_pkg::CMD_AUTOINC_BIT] = inc;
		w[dbg_pkg::CMD_CLEAR_BIT]   = clr;
		return w;
	endfunction

	task automatic hand_over(input logic apply, input dbg_pkg::dbg_word_t word, input logic sel);
		hand_valid = apply;
		hand_check = !apply;
		hand_word  = word;
		hand_sel   = sel;
		@(negedge clk48m);
		hand_valid = 1'b0;
		hand_check = 1'b0;
	endtask

	// one tck period with the low half first and inputs held throughout
	task automatic tck_pulse(input logic tdi, input logic shift, input logic update);
		@(negedge clk48m);
		jtck    = 1'b0;
		jtdi    = tdi;
		jshift  = shift;
		jupdate = update;
		repeat (HALF_TCK) @(negedge clk48m);
		jtck = 1'b1;
		if (shd_model) begin
			sr_model = {tdi, sr_model[31:1]};
		end
		if (update) begin
			cap_word = sr_model;
		end
		shd_model = shift;
		repeat (HALF_TCK - 1) @(negedge clk48m);
	endtask

	// enter shift and send nbits of tdi lsb first before an optional update
	task automatic scan_dr(input dbg_pkg::dbg_word_t word, input int nbits, input logic update,
			input logic sel);
		@(negedge clk48m);
		jce1 = (sel == dbg_pkg::SEL_CMD);
		jce2 = (sel == dbg_pkg::SEL_DATA);
		tck_pulse(1'b0, 1'b1, 1'b0);
		for (int i = 0; i < nbits; i++) begin
			tck_pulse(word[i], (i != nbits - 1), 1'b0); // shift drops before the last bit
		end
		if (update) begin
			tck_pulse(1'b0, 1'b0, 1'b1);
		end
		@(negedge clk48m);
		jtck    = 1'b0;
		jtdi    = 1'b0;
		jshift  = 1'b0;
		jupdate = 1'b0;
		jce1    = 1'b0;
		jce2    = 1'b0;
		scan_count++;
		if (update) begin
			hand_over(1'b1, cap_word, sel);
		end
		repeat (8) @(negedge clk48m);
	endtask

	task automatic send_cmd(input int addr, input logic inc);
		scan_dr(make_cmd(addr, inc, 1'b0), 32, 1'b1, dbg_pkg::SEL_CMD);
	endtask

	task automatic send_data(input dbg_pkg::dbg_word_t w);
		scan_dr(w, 32, 1'b1, dbg_pkg::SEL_DATA);
	endtask

	task automatic check_now();
		hand_over(1'b0, '0, dbg_pkg::SEL_CMD);
		repeat (8) @(negedge clk48m);
	endtask

	always @(posedge clk48m) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		dbg_pkg::dbg_word_t w;
		clk48m     = 1'b0;
		jrstn      = 1'b0;
		jtck       = 1'b0;
		jtdi       = 1'b0;
		jshift     = 1'b0;
		jupdate    = 1'b0;
		jce1       = 1'b0;
		jce2       = 1'b0;
		hand_valid = 1'b0;
		hand_check = 1'b0;
		hand_word  = '0;
		hand_sel   = 1'b0;
		lfsr_state = 32'ha548;
		sr_model   = '0;
		shd_model  = 1'b0;
		cap_word   = '0;
		scan_count = 0;
		repeat (10) @(negedge clk48m);
		jrstn = 1'b1;
		repeat (4) @(negedge clk48m);
		check_now(); // reset values

		// single writes where address 0 also drives the control word
		send_cmd(3, 1'b0);
		rand_word(w);
		send_data(w);
		send_cmd(0, 1'b0);
		rand_word(w);
		send_data(w);
		send_cmd(9, 1'b0);
		rand_word(w);
		send_data(w);

		// auto-increment burst across the top of the bank and its readback
		send_cmd(14, 1'b1);
		for (int n = 0; n < 4; n++) begin
			rand_word(w);
			send_data(w);
		end
		for (int a = 14; a < 18; a++) begin
			send_cmd(a % REG_COUNT, 1'b0);
		end

		// shifting without update and partial shifts with update
		rand_word(w);
		scan_dr(w, 32, 1'b0, dbg_pkg::SEL_DATA);
		check_now();
		rand_word(w);
		scan_dr(w, 12, 1'b1, dbg_pkg::SEL_DATA);
		rand_word(w);
		scan_dr(w, 20, 1'b1, dbg_pkg::SEL_DATA);

		// clear overrides the other command fields and sends the address back to 0
		scan_dr(make_cmd(5, 1'b1, 1'b1), 32, 1'b1, dbg_pkg::SEL_CMD);
		rand_word(w);
		send_data(w);
		send_cmd(14, 1'b0);
		send_cmd(0, 1'b0);
		send_cmd(9, 1'b0);

		$display("%0d scans, %0d checks, %0d errors", scan_count, check_count, err_count);
		if (err_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: verilog.f
design/dbg_pkg.sv
design/jtag_dr_capture.sv
design/dbg_cmd_decoder.sv
design/dbg_regfile.sv
design/jtag_debug_bridge.sv
bench/dbg_checker.sv
bench/tb_jtag_debug.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the JTAG debug bridge simulation with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_jtag_debug \
	-f verilog.f \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
